// File: dv/tb_exu_top.sv
`timescale 1ns/1ps

module tb_exu_top import exu_pkg::*; ();

    localparam int n_warm      = 31;
    localparam int n_lat       = 200;
    localparam int n_tests     = 2000;
    localparam int watchdog_ns = n_tests * 20 * 4;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  in_valid;
    logic                  in_ready;
    logic [31:0]           in_instr;
    logic [xlen-1:0]       in_pc;
    logic                  out_valid;
    logic                  out_ready;
    logic [reg_addr_w-1:0] out_rd;
    logic [xlen-1:0]       out_wdata;
    logic                  out_we;
    logic [xlen-1:0]       out_next_pc;
    logic                  out_illegal;

    logic [31:0] rng_state = 32'hdde8;
    logic [63:0] model_regs [32];
    logic [63:0] pc;
    logic [4:0]  last_rd;
    logic        gaps_on;
    logic        lat_mode;
    logic        ready_next;
    int          cyc = 0;
    int          n_out = 0;
    logic [31:0] q_instr [$];
    logic [63:0] q_pc [$];
    int          q_edge [$];
    logic        q_lat [$];

    exu_top i_dut (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_instr    (in_instr),
        .in_pc       (in_pc),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_rd      (out_rd),
        .out_wdata   (out_wdata),
        .out_we      (out_we),
        .out_next_pc (out_next_pc),
        .out_illegal (out_illegal)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic bit is_legal_opcode(input logic [6:0] opc);
        return opc inside {opc_op, opc_op_imm, opc_op_32, opc_op_imm_32, opc_lui,
                           opc_auipc, opc_jal, opc_jalr, opc_branch};
    endfunction

    function automatic logic [31:0] gen_instr();
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [2:0]  wf3;
        logic [6:0]  f7;
        logic [6:0]  wf7;
        logic [11:0] imm;
        logic [6:0]  opc;
        r1  = xorshift32();
        r2  = xorshift32();
        r3  = xorshift32();
        rd  = r1[4:0];
        // lean on the previous rd so forwarding gets exercised
        rs1 = (r1[17:15] == 3'd0) ? last_rd : r1[9:5];
        rs2 = (r1[20:18] == 3'd0) ? last_rd : r1[14:10];
        f3  = r1[23:21];
        f7  = (r1[24] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'b0100000 : 7'b0;
        // word forms only have add/sub, sll and the right shifts
        wf3 = (r2[13:12] == 2'd0) ? 3'b000 : (r2[13:12] == 2'd1) ? 3'b001 : 3'b101;
        wf7 = (r1[24] && wf3 != 3'b001) ? 7'b0100000 : 7'b0;
        imm = r2[11:0];
        case (r2[31:28])
            4'd0, 4'd1, 4'd2: return {f7, rs2, rs1, f3, rd, opc_op};
            4'd3, 4'd4, 4'd5: begin
                if (f3 == 3'b001 || f3 == 3'b101) begin
                    imm = {f7[6:1], r2[5:0]};
                end
                return {imm, rs1, f3, rd, opc_op_imm};
            end
            4'd6:  return {wf7, rs2, rs1, wf3, rd, opc_op_32};
            4'd7: begin
                if (wf3 != 3'b000) begin
                    imm = {wf7, r2[4:0]};
                end
                return {imm, rs1, wf3, rd, opc_op_imm_32};
            end
            4'd8:  return {r3[31:12], rd, opc_lui};
            4'd9:  return {r3[31:12], rd, opc_auipc};
            4'd10: return {r3[31:12], rd, opc_jal};
            4'd11: return {imm, rs1, 3'b000, rd, opc_jalr};
            4'd12, 4'd13: begin
                f3 = r2[14:12];
                if (f3 == 3'b010 || f3 == 3'b011) begin
                    f3 = f3 ^ 3'b110;
                end
                if (r2[16:15] == 2'd0) begin
                    rs2 = rs1;
                end
                return {r3[31:25], rs2, rs1, f3, r3[11:7], opc_branch};
            end
            4'd14: begin
                opc = r3[6:0];
                while (is_legal_opcode(opc)) begin
                    r3  = xorshift32();
                    opc = r3[6:0];
                end
                return {r2[24:0], opc};
            end
            // addi into x0
            default: return {imm, rs1, 3'b000, 5'd0, opc_op_imm};
        endcase
    endfunction

    function automatic logic [63:0] alu64(input logic [2:0] f3, input logic alt,
                                          input logic [63:0] a, input logic [63:0] b);
        logic [63:0] r;
        case (f3)
            3'b000: r = alt ? a - b : a + b;
            3'b001: r = a << b[5:0];
            3'b010: r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            3'b011: r = (a < b) ? 64'd1 : 64'd0;
            3'b100: r = a ^ b;
            3'b101: begin
                if (alt) begin
                    r = $signed(a) >>> b[5:0];
                end else begin
                    r = a >> b[5:0];
                end
            end
            3'b110: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic [63:0] alu32(input logic [2:0] f3, input logic alt,
                                          input logic [63:0] a, input logic [63:0] b);
        logic [31:0] lo;
        logic [31:0] r;
        lo = a[31:0];
        case (f3)
            3'b000: r = alt ? lo - b[31:0] : lo + b[31:0];
            3'b001: r = lo << b[4:0];
            3'b101: begin
                if (alt) begin
                    r = $signed(lo) >>> b[4:0];
                end else begin
                    r = lo >> b[4:0];
                end
            end
            default: r = 32'd0;
        endcase
        return {{32{r[31]}}, r};
    endfunction

    // architectural result of one instruction against the model registers
    function automatic void predict_result(input logic [31:0] instr, input logic [63:0] ipc,
                                           output logic exp_we, output logic [63:0] exp_wdata,
                                           output logic [63:0] exp_npc,
                                           output logic exp_illegal);
        logic [2:0]  f3;
        logic        alt;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] imm_i;
        logic [63:0] imm_b;
        logic [63:0] imm_u;
        logic [63:0] imm_j;
        logic [63:0] target;
        logic        taken;
        f3          = instr[14:12];
        alt         = instr[30];
        a           = model_regs[instr[19:15]];
        b           = model_regs[instr[24:20]];
        imm_i       = {{52{instr[31]}}, instr[31:20]};
        imm_b       = {{52{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        imm_u       = {{32{instr[31]}}, instr[31:12], 12'b0};
        imm_j       = {{44{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        exp_we      = 1'b1;
        exp_wdata   = 64'd0;
        exp_npc     = ipc + 64'd4;
        exp_illegal = 1'b0;
        case (instr[6:0])
            opc_op:        exp_wdata = alu64(f3, alt, a, b);
            opc_op_imm:    exp_wdata = alu64(f3, alt && f3 == 3'b101, a, imm_i);
            opc_op_32:     exp_wdata = alu32(f3, alt, a, b);
            opc_op_imm_32: exp_wdata = alu32(f3, alt && f3 == 3'b101, a, imm_i);
            opc_lui:       exp_wdata = imm_u;
            opc_auipc:     exp_wdata = ipc + imm_u;
            opc_jal: begin
                exp_wdata = ipc + 64'd4;
                exp_npc   = ipc + imm_j;
            end
            opc_jalr: begin
                exp_wdata = ipc + 64'd4;
                target    = a + imm_i;
                exp_npc   = {target[63:1], 1'b0};
            end
            opc_branch: begin
                exp_we = 1'b0;
                case (f3)
                    3'b000:  taken = (a == b);
                    3'b001:  taken = (a != b);
                    3'b100:  taken = ($signed(a) < $signed(b));
                    3'b101:  taken = ($signed(a) >= $signed(b));
                    3'b110:  taken = (a < b);
                    default: taken = (a >= b);
                endcase
                if (taken) begin
                    exp_npc = ipc + imm_b;
                end
            end
            default: begin
                exp_we      = 1'b0;
                exp_illegal = 1'b1;
            end
        endcase
    endfunction

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("Done: errors found");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_output();
        logic [31:0] instr;
        logic [63:0] ipc;
        logic        exp_we;
        logic [63:0] exp_wdata;
        logic [63:0] exp_npc;
        logic        exp_illegal;
        int          acc_edge;
        logic        lat;
        if (q_instr.size() == 0) begin
            $display("A result came out with no accepted instruction waiting at %0t", $time);
            $display("Done: errors found");
            $fatal(1, "extra result");
        end else begin
            instr    = q_instr.pop_front();
            ipc      = q_pc.pop_front();
            acc_edge = q_edge.pop_front();
            lat      = q_lat.pop_front();
            predict_result(instr, ipc, exp_we, exp_wdata, exp_npc, exp_illegal);
            check_value("out_rd", 64'(out_rd), 64'(instr[11:7]));
            check_value("out_illegal", 64'(out_illegal), 64'(exp_illegal));
            check_value("out_we", 64'(out_we), 64'(exp_we));
            check_value("out_next_pc", out_next_pc, exp_npc);
            if (exp_we) begin
                check_value("out_wdata", out_wdata, exp_wdata);
            end
            if (lat) begin
                check_value("latency", 64'(cyc + 1 - acc_edge), 64'd2);
            end
            if (exp_we && instr[11:7] != 5'd0) begin
                model_regs[instr[11:7]] = exp_wdata;
            end
            n_out = n_out + 1;
        end
    endtask

    // handshakes sampled at the falling edge before their transfer edge
    always @(negedge clk) begin
        if (!rst) begin
            if (out_valid && out_ready) begin
                check_output();
            end
            if (in_valid && in_ready) begin
                q_instr.push_back(in_instr);
                q_pc.push_back(in_pc);
                q_edge.push_back(cyc + 1);
                q_lat.push_back(lat_mode);
            end
        end
    end

    task automatic send_instr(input logic [31:0] instr);
        logic [31:0] r;
        int          gap;
        logic        done;
        r   = xorshift32();
        gap = (gaps_on && r[1:0] == 2'b00) ? int'(r[3:2]) + 1 : 0;
        repeat (gap) begin
            in_valid = 1'b0;
            @(posedge clk);
            #0.5;
        end
        in_valid = 1'b1;
        in_instr = instr;
        in_pc    = pc;
        done     = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = in_ready;
            @(posedge clk);
            #0.5;
        end
        pc      = pc + 64'd4;
        last_rd = instr[11:7];
    endtask

    initial begin
        out_ready = 1'b0;
        forever begin
            @(negedge clk);
            ready_next = lat_mode || (xorshift32() % 10 >= 3);
            @(posedge clk);
            #0.5;
            out_ready = ready_next;
        end
    end

    initial begin
        rst      = 1'b1;
        // an instruction offered during reset must not get in
        in_valid = 1'b1;
        in_instr = {12'd1, 5'd0, 3'b000, 5'd1, opc_op_imm};
        in_pc    = 64'd0;
        gaps_on  = 1'b0;
        lat_mode = 1'b0;
        last_rd  = 5'd0;
        for (int k = 0; k < 32; k++) begin
            model_regs[k] = 64'd0;
        end
        pc = {xorshift32(), xorshift32() & 32'hffff_fffc};
        repeat (16) @(posedge clk);
        #0.5;
        rst      = 1'b0;
        in_valid = 1'b0;
        @(negedge clk);
        check_value("out_valid after reset", 64'(out_valid), 64'd0);
        check_value("in_ready after reset", 64'(in_ready), 64'd1);
        @(posedge clk);
        #0.5;
        // addi xN, x0, imm for every register
        for (int k = 1; k <= n_warm; k++) begin
            send_instr({xorshift32() & 32'hfff0_0000 | 32'(k << 7) | 32'(opc_op_imm)});
        end
        gaps_on = 1'b1;
        for (int k = 0; k < n_tests - n_warm - n_lat; k++) begin
            send_instr(gen_instr());
        end
        // fixed latency run without gaps or stalls
        gaps_on  = 1'b0;
        lat_mode = 1'b1;
        in_valid = 1'b0;
        @(posedge clk);
        #0.5;
        for (int k = 0; k < n_lat; k++) begin
            send_instr(gen_instr());
        end
        in_valid = 1'b0;
        while (n_out < n_tests) begin
            @(posedge clk);
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        $display("Done: no errors");
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("Timeout: the run did not finish within %0d ns", watchdog_ns);
        $display("Done: errors found");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: hw/exu_alu.sv
`timescale 1ns/1ps

module exu_alu import exu_pkg::*; (
    input  alu_op_e         op,
    input  logic            word,
    input  logic [xlen-1:0] src1,
    input  logic [xlen-1:0] src2,
    output logic [xlen-1:0] result
);

    logic [5:0]      shamt;
    logic [xlen-1:0] srl_res;
    logic [xlen-1:0] sra_res;
    logic [31:0]     sra_word;

    // word forms shift by 5 bits only
    assign shamt = word ? {1'b0, src2[4:0]} : src2[5:0];

    assign sra_word = $signed(src1[31:0]) >>> src2[4:0];

    always_comb begin
        if (word) begin
            srl_res = {32'b0, src1[31:0]} >> shamt;
            sra_res = {{32{sra_word[31]}}, sra_word};
        end else begin
            srl_res = src1 >> shamt;
            sra_res = $signed(src1) >>> shamt;
        end
    end

    always_comb begin
        case (op)
            add:     result = src1 + src2;
            sub:     result = src1 - src2;
            sll:     result = src1 << shamt;
            slt:     result = {{(xlen-1){1'b0}}, $signed(src1) < $signed(src2)};
            sltu:    result = {{(xlen-1){1'b0}}, src1 < src2};
            xor_op:  result = src1 ^ src2;
            srl:     result = srl_res;
            sra:     result = sra_res;
            or_op:   result = src1 | src2;
            and_op:  result = src1 & src2;
            pass_b:  result = src2;
            default: result = '0;
        endcase
    end

endmodule

// File: hw/exu_ctrl_if.sv
`timescale 1ns/1ps

interface exu_ctrl_if import exu_pkg::*; ();

    logic                  valid;
    logic                  ready;
    logic [xlen-1:0]       pc;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rd;
    // instr[31:7]
    logic [24:0]           imm_raw;
    imm_sel_e              imm_sel;
    src1_sel_e             src1_sel;
    src2_sel_e             src2_sel;
    alu_op_e               alu_op;
    next_pc_sel_e          next_pc_sel;
    logic                  word;
    logic                  illegal;
    logic                  we;

    modport dec (
        output valid, pc, rs1, rs2, rd, imm_raw, imm_sel, src1_sel, src2_sel,
               alu_op, next_pc_sel, word, illegal, we,
        input  ready
    );

    modport exe (
        input  valid, pc, rs1, rs2, rd, imm_raw, imm_sel, src1_sel, src2_sel,
               alu_op, next_pc_sel, word, illegal, we,
        output ready
    );

endinterface

// File: hw/exu_decoder.sv
`timescale 1ns/1ps

module exu_decoder import exu_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            in_valid,
    input  logic [31:0]     in_instr,
    input  logic [xlen-1:0] in_pc,
    output logic            in_ready,
    exu_ctrl_if.dec         ctrl
);

    logic [6:0]   opcode;
    logic [2:0]   funct3;
    logic         alt;
    logic         accept;

    alu_op_e      d_alu_op;
    imm_sel_e     d_imm_sel;
    src1_sel_e    d_src1_sel;
    src2_sel_e    d_src2_sel;
    next_pc_sel_e d_next_pc_sel;
    logic         d_word;
    logic         d_illegal;
    logic         d_we;

    // sub only exists in the register forms
    function automatic alu_op_e funct_to_alu(input logic [2:0] f3, input logic alt_bit,
                                             input logic sub_ok);
        alu_op_e r;
        case (f3)
            3'b000:  r = (alt_bit && sub_ok) ? sub : add;
            3'b001:  r = sll;
            3'b010:  r = slt;
            3'b011:  r = sltu;
            3'b100:  r = xor_op;
            3'b101:  r = alt_bit ? sra : srl;
            3'b110:  r = or_op;
            default: r = and_op;
        endcase
        return r;
    endfunction

    assign opcode = in_instr[6:0];
    assign funct3 = in_instr[14:12];
    assign alt    = in_instr[30];

    always_comb begin
        d_alu_op      = add;
        d_imm_sel     = imm_i;
        d_src1_sel    = src1_rs1;
        d_src2_sel    = src2_rs2;
        d_next_pc_sel = npc_seq;
        d_word        = 1'b0;
        d_illegal     = 1'b0;
        d_we          = 1'b1;
        case (opcode)
            opc_op, opc_op_32: begin
                d_alu_op = funct_to_alu(funct3, alt, 1'b1);
                d_word   = (opcode == opc_op_32);
            end
            opc_op_imm, opc_op_imm_32: begin
                d_alu_op   = funct_to_alu(funct3, alt, 1'b0);
                d_src2_sel = src2_imm;
                d_word     = (opcode == opc_op_imm_32);
            end
            opc_lui: begin
                d_alu_op   = pass_b;
                d_imm_sel  = imm_u;
                d_src1_sel = src1_zero;
                d_src2_sel = src2_imm;
            end
            opc_auipc: begin
                d_imm_sel  = imm_u;
                d_src1_sel = src1_pc;
                d_src2_sel = src2_imm;
            end
            // link value pc + 4 goes through the ALU
            opc_jal: begin
                d_imm_sel     = imm_j;
                d_src1_sel    = src1_pc;
                d_src2_sel    = src2_four;
                d_next_pc_sel = npc_jal;
            end
            opc_jalr: begin
                d_src1_sel    = src1_pc;
                d_src2_sel    = src2_four;
                d_next_pc_sel = npc_jalr;
            end
            opc_branch: begin
                d_imm_sel = imm_b;
                d_we      = 1'b0;
                case (funct3)
                    3'b000:  d_next_pc_sel = npc_beq;
                    3'b001:  d_next_pc_sel = npc_bne;
                    3'b100:  d_next_pc_sel = npc_blt;
                    3'b101:  d_next_pc_sel = npc_bge;
                    3'b110:  d_next_pc_sel = npc_bltu;
                    3'b111:  d_next_pc_sel = npc_bgeu;
                    default: d_next_pc_sel = npc_seq;
                endcase
            end
            default: begin
                d_illegal = 1'b1;
                d_we      = 1'b0;
            end
        endcase
    end

    // decode register empty or moving on this cycle
    assign in_ready = ~ctrl.valid | ctrl.ready;
    assign accept   = in_valid & in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl.valid <= 1'b0;
        end else if (accept) begin
            ctrl.valid <= 1'b1;
        end else if (ctrl.ready) begin
            ctrl.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ctrl.pc          <= in_pc;
            ctrl.rs1         <= in_instr[19:15];
            ctrl.rs2         <= in_instr[24:20];
            ctrl.rd          <= in_instr[11:7];
            ctrl.imm_raw     <= in_instr[31:7];
            ctrl.imm_sel     <= d_imm_sel;
            ctrl.src1_sel    <= d_src1_sel;
            ctrl.src2_sel    <= d_src2_sel;
            ctrl.alu_op      <= d_alu_op;
            ctrl.next_pc_sel <= d_next_pc_sel;
            ctrl.word        <= d_word;
            ctrl.illegal     <= d_illegal;
            ctrl.we          <= d_we;
        end
    end

endmodule

// File: hw/exu_execute.sv
`timescale 1ns/1ps

module exu_execute import exu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    exu_ctrl_if.exe               ctrl,
    output logic [reg_addr_w-1:0] rf_addr1,
    output logic [reg_addr_w-1:0] rf_addr2,
    input  logic [xlen-1:0]       rf_data1,
    input  logic [xlen-1:0]       rf_data2,
    output logic                  wr_en,
    output logic [reg_addr_w-1:0] wr_addr,
    output logic [xlen-1:0]       wr_data,
    output alu_op_e               alu_op,
    output logic                  alu_word,
    output logic [xlen-1:0]       alu_src1,
    output logic [xlen-1:0]       alu_src2,
    input  logic [xlen-1:0]       alu_result,
    output logic                  out_valid,
    input  logic                  out_ready,
    output logic [reg_addr_w-1:0] out_rd,
    output logic [xlen-1:0]       out_wdata,
    output logic                  out_we,
    output logic [xlen-1:0]       out_next_pc,
    output logic                  out_illegal
);

    logic [xlen-1:0] imm_i_ext, imm_s_ext, imm_b_ext, imm_u_ext, imm_j_ext;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] fwd1, fwd2;
    logic [xlen-1:0] wdata;
    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] jalr_sum;
    logic [xlen-1:0] next_pc;
    logic            taken;
    logic            capture;

    // imm_raw holds instr[31:7], so instr[k] is imm_raw[k-7]
    assign imm_i_ext = {{52{ctrl.imm_raw[24]}}, ctrl.imm_raw[24:13]};
    assign imm_s_ext = {{52{ctrl.imm_raw[24]}}, ctrl.imm_raw[24:18], ctrl.imm_raw[4:0]};
    assign imm_b_ext = {{52{ctrl.imm_raw[24]}}, ctrl.imm_raw[0], ctrl.imm_raw[23:18],
                        ctrl.imm_raw[4:1], 1'b0};
    assign imm_u_ext = {{32{ctrl.imm_raw[24]}}, ctrl.imm_raw[24:5], 12'b0};
    assign imm_j_ext = {{44{ctrl.imm_raw[24]}}, ctrl.imm_raw[12:5], ctrl.imm_raw[13],
                        ctrl.imm_raw[23:14], 1'b0};

    always_comb begin
        case (ctrl.imm_sel)
            imm_s:   imm = imm_s_ext;
            imm_b:   imm = imm_b_ext;
            imm_u:   imm = imm_u_ext;
            imm_j:   imm = imm_j_ext;
            default: imm = imm_i_ext;
        endcase
    end

    assign rf_addr1 = ctrl.rs1;
    assign rf_addr2 = ctrl.rs2;

    // result still waiting in the output register wins over the regfile
    assign fwd1 = (out_valid && out_we && ctrl.rs1 != '0 && out_rd == ctrl.rs1) ?
                  out_wdata : rf_data1;
    assign fwd2 = (out_valid && out_we && ctrl.rs2 != '0 && out_rd == ctrl.rs2) ?
                  out_wdata : rf_data2;

    always_comb begin
        case (ctrl.src1_sel)
            src1_pc:   alu_src1 = ctrl.pc;
            src1_zero: alu_src1 = '0;
            default:   alu_src1 = fwd1;
        endcase
        case (ctrl.src2_sel)
            src2_imm:  alu_src2 = imm;
            src2_four: alu_src2 = 64'd4;
            default:   alu_src2 = fwd2;
        endcase
    end

    assign alu_op   = ctrl.alu_op;
    assign alu_word = ctrl.word;

    // word forms sign-extend from bit 31
    assign wdata = ctrl.word ? {{32{alu_result[31]}}, alu_result[31:0]} : alu_result;

    always_comb begin
        case (ctrl.next_pc_sel)
            npc_beq:  taken = (fwd1 == fwd2);
            npc_bne:  taken = (fwd1 != fwd2);
            npc_blt:  taken = ($signed(fwd1) < $signed(fwd2));
            npc_bge:  taken = ($signed(fwd1) >= $signed(fwd2));
            npc_bltu: taken = (fwd1 < fwd2);
            npc_bgeu: taken = (fwd1 >= fwd2);
            default:  taken = 1'b0;
        endcase
    end

    assign pc_plus4 = ctrl.pc + 64'd4;
    assign jalr_sum = fwd1 + imm_i_ext;

    always_comb begin
        case (ctrl.next_pc_sel)
            npc_jal:  next_pc = ctrl.pc + imm_j_ext;
            npc_jalr: next_pc = {jalr_sum[xlen-1:1], 1'b0};
            npc_seq:  next_pc = pc_plus4;
            default:  next_pc = taken ? ctrl.pc + imm_b_ext : pc_plus4;
        endcase
    end

    // output register empty or draining
    assign ctrl.ready = ~out_valid | out_ready;
    assign capture    = ctrl.valid & ctrl.ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            out_we    <= 1'b0;
        end else if (capture) begin
            out_valid <= 1'b1;
            out_we    <= ctrl.we;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            out_rd      <= ctrl.rd;
            out_wdata   <= wdata;
            out_next_pc <= next_pc;
            out_illegal <= ctrl.illegal;
        end
    end

    // write-back on acceptance keeps program order
    assign wr_en   = out_valid & out_ready & out_we & (out_rd != '0);
    assign wr_addr = out_rd;
    assign wr_data = out_wdata;

endmodule

// File: hw/exu_pkg.sv
package exu_pkg;

    localparam int xlen       = 64;
    localparam int reg_addr_w = 5;

    typedef enum logic [3:0] {
        add,
        sub,
        sll,
        slt,
        sltu,
        xor_op,
        srl,
        sra,
        or_op,
        and_op,
        pass_b
    } alu_op_e;

    typedef enum logic [1:0] {
        src1_rs1,
        src1_pc,
        src1_zero
    } src1_sel_e;

    typedef enum logic [1:0] {
        src2_rs2,
        src2_imm,
        src2_four
    } src2_sel_e;

    typedef enum logic [2:0] {
        imm_i,
        imm_s,
        imm_b,
        imm_u,
        imm_j
    } imm_sel_e;

    typedef enum logic [3:0] {
        npc_seq,
        npc_jal,
        npc_jalr,
        npc_beq,
        npc_bne,
        npc_blt,
        npc_bge,
        npc_bltu,
        npc_bgeu
    } next_pc_sel_e;

    // major opcodes in instr[6:0]
    localparam logic [6:0] opc_op        = 7'b0110011;
    localparam logic [6:0] opc_op_imm    = 7'b0010011;
    localparam logic [6:0] opc_op_32     = 7'b0111011;
    localparam logic [6:0] opc_op_imm_32 = 7'b0011011;
    localparam logic [6:0] opc_lui       = 7'b0110111;
    localparam logic [6:0] opc_auipc     = 7'b0010111;
    localparam logic [6:0] opc_jal       = 7'b1101111;
    localparam logic [6:0] opc_jalr      = 7'b1100111;
    localparam logic [6:0] opc_branch    = 7'b1100011;

endpackage

// File: hw/exu_regfile.sv
`timescale 1ns/1ps

module exu_regfile import exu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [reg_addr_w-1:0] rd_addr1,
    input  logic [reg_addr_w-1:0] rd_addr2,
    output logic [xlen-1:0]       rd_data1,
    output logic [xlen-1:0]       rd_data2,
    input  logic                  wr_en,
    input  logic [reg_addr_w-1:0] wr_addr,
    input  logic [xlen-1:0]       wr_data
);

    localparam int num_regs = 2 ** reg_addr_w;

    logic [xlen-1:0] regs [num_regs];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < num_regs; k++) begin
                regs[k] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            // x0 never written, so it stays zero
            regs[wr_addr] <= wr_data;
        end
    end

    assign rd_data1 = regs[rd_addr1];
    assign rd_data2 = regs[rd_addr2];

endmodule

// File: hw/exu_top.sv
`timescale 1ns/1ps

module exu_top import exu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  logic [31:0]           in_instr,
    input  logic [xlen-1:0]       in_pc,
    output logic                  out_valid,
    input  logic                  out_ready,
    output logic [reg_addr_w-1:0] out_rd,
    output logic [xlen-1:0]       out_wdata,
    output logic                  out_we,
    output logic [xlen-1:0]       out_next_pc,
    output logic                  out_illegal
);

    logic [reg_addr_w-1:0] rf_addr1, rf_addr2;
    logic [xlen-1:0]       rf_data1, rf_data2;
    logic                  wr_en;
    logic [reg_addr_w-1:0] wr_addr;
    logic [xlen-1:0]       wr_data;
    alu_op_e               alu_op;
    logic                  alu_word;
    logic [xlen-1:0]       alu_src1, alu_src2;
    logic [xlen-1:0]       alu_result;

    exu_ctrl_if ctrl ();

    exu_decoder u_decoder (
        .clk      (clk      ),
        .rst      (rst      ),
        .in_valid (in_valid ),
        .in_instr (in_instr ),
        .in_pc    (in_pc    ),
        .in_ready (in_ready ),
        .ctrl     (ctrl.dec )
    );

    // register file beside the stage it feeds
    exu_regfile u_regfile (
        .clk      (clk      ),
        .rst      (rst      ),
        .rd_addr1 (rf_addr1 ),
        .rd_addr2 (rf_addr2 ),
        .rd_data1 (rf_data1 ),
        .rd_data2 (rf_data2 ),
        .wr_en    (wr_en    ),
        .wr_addr  (wr_addr  ),
        .wr_data  (wr_data  )
    );

    exu_execute u_execute (
        .clk         (clk         ),
        .rst         (rst         ),
        .ctrl        (ctrl.exe    ),
        .rf_addr1    (rf_addr1    ),
        .rf_addr2    (rf_addr2    ),
        .rf_data1    (rf_data1    ),
        .rf_data2    (rf_data2    ),
        .wr_en       (wr_en       ),
        .wr_addr     (wr_addr     ),
        .wr_data     (wr_data     ),
        .alu_op      (alu_op      ),
        .alu_word    (alu_word    ),
        .alu_src1    (alu_src1    ),
        .alu_src2    (alu_src2    ),
        .alu_result  (alu_result  ),
        .out_valid   (out_valid   ),
        .out_ready   (out_ready   ),
        .out_rd      (out_rd      ),
        .out_wdata   (out_wdata   ),
        .out_we      (out_we      ),
        .out_next_pc (out_next_pc ),
        .out_illegal (out_illegal )
    );

    exu_alu u_alu (
        .op     (alu_op     ),
        .word   (alu_word   ),
        .src1   (alu_src1   ),
        .src2   (alu_src2   ),
        .result (alu_result )
    );

endmodule

// File: list.f
hw/exu_pkg.sv
hw/exu_ctrl_if.sv
hw/exu_decoder.sv
hw/exu_regfile.sv
hw/exu_alu.sv
hw/exu_execute.sv
hw/exu_top.sv
dv/tb_exu_top.sv

// File: run.sh
#!/bin/sh
# build and run with Verilator, verdict taken from the log
rm -f sim.log &&
verilator --binary --top-module tb_exu_top -f list.f -o sim_exu &&
./obj_dir/sim_exu | tee sim.log
grep -q "Done: no errors" sim.log && echo PASS || { echo FAIL; exit 1; }
